/* logic/lcd_pkg.sv */
package lcd_pkg;

  // Timer width, wide enough for the power-on wait at the full clock rate
  localparam int CNT_W = 20;

  // Sequence layout: command writes first, then the message characters
  localparam int NUM_CMDS  = 8;
  localparam int MSG_LEN   = 14;
  localparam int NUM_STEPS = NUM_CMDS + MSG_LEN;

  // HD44780 command bytes
  localparam logic [7:0] CMD_WAKE       = 8'h30;
  localparam logic [7:0] CMD_FUNC_SET   = 8'h38;
  localparam logic [7:0] CMD_ENTRY_MODE = 8'h06;
  localparam logic [7:0] CMD_DISPLAY_ON = 8'h0C;
  localparam logic [7:0] CMD_CLEAR      = 8'h01;
  localparam logic [7:0] CMD_ROW0_HOME  = 8'h80;

  // First character sits in the top byte
  localparam logic [MSG_LEN-1:0][7:0] MSG_LANDING = "FLIGHT LANDING";
  localparam logic [MSG_LEN-1:0][7:0] MSG_TAKEOFF = "FLIGHT TAKEOFF";

  typedef logic [$clog2(NUM_STEPS)-1:0] step_idx_t;

  typedef enum logic {
    msg_landing,
    msg_takeoff
  } msg_sel_t;

  // Hold-off kinds after a write
  typedef enum logic [2:0] {
    dly_wake_long,
    dly_wake_short,
    dly_cmd,
    dly_clear
  } delay_class_t;

  // Pins of the 8-bit LCD bus
  typedef struct packed {
    logic       e;
    logic       rs;
    logic [7:0] data;
  } lcd_bus_t;

  // One entry of the write sequence
  typedef struct packed {
    logic         rs;
    logic [7:0]   data;
    delay_class_t dly;
  } lcd_step_t;

endpackage

/* logic/lcd_delay_timer.sv */
`timescale 1ns/1ps

module lcd_delay_timer (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     load,
  input  logic [lcd_pkg::CNT_W-1:0] load_value,
  output logic                     expired
);
  import lcd_pkg::*;

  logic [CNT_W-1:0] count;
  logic             idle;

  // Count reaches zero exactly load_value cycles after the load
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      count <= '0;
      idle  <= 1'b1;
    end else if (load) begin
      count <= load_value - CNT_W'(1);
      idle  <= 1'b0;
    end else if (!idle) begin
      if (count == '0) begin
        idle <= 1'b1;
      end else begin
        count <= count - CNT_W'(1);
      end
    end
  end

  assign expired = !idle && (count == '0);

  a_load_nonzero: assert property (@(posedge clk) disable iff (rst)
    load |-> load_value != '0);

endmodule

/* logic/lcd_step_rom.sv */
`timescale 1ns/1ps

module lcd_step_rom (
  input  lcd_pkg::step_idx_t step_idx,
  input  lcd_pkg::msg_sel_t  active_mode,
  output lcd_pkg::lcd_step_t step
);
  import lcd_pkg::*;

  logic [MSG_LEN-1:0][7:0] msg;
  step_idx_t               char_idx;

  assign msg      = (active_mode == msg_takeoff) ? MSG_TAKEOFF : MSG_LANDING;
  assign char_idx = step_idx - step_idx_t'(NUM_CMDS);

  always_comb begin
    step = '{rs: 1'b0, data: 8'h00, dly: dly_cmd};
    case (step_idx)
      // Wake-up, the first one needs the long settle
      0: begin
        step = '{rs: 1'b0, data: CMD_WAKE, dly: dly_wake_long};
      end
      1, 2: begin
        step = '{rs: 1'b0, data: CMD_WAKE, dly: dly_wake_short};
      end
      3: begin
        step = '{rs: 1'b0, data: CMD_FUNC_SET, dly: dly_cmd};
      end
      4: begin
        step = '{rs: 1'b0, data: CMD_ENTRY_MODE, dly: dly_cmd};
      end
      5: begin
        step = '{rs: 1'b0, data: CMD_DISPLAY_ON, dly: dly_cmd};
      end
      // Clear is the slow command
      6: begin
        step = '{rs: 1'b0, data: CMD_CLEAR, dly: dly_clear};
      end
      7: begin
        step = '{rs: 1'b0, data: CMD_ROW0_HOME, dly: dly_cmd};
      end
      default: begin
        if (step_idx < step_idx_t'(NUM_STEPS)) begin
          step.rs   = 1'b1;
          step.data = msg[MSG_LEN - 1 - int'(char_idx)];
          step.dly  = dly_cmd;
        end
      end
    endcase
  end

endmodule

/* logic/lcd_sequencer.sv */
`timescale 1ns/1ps

module lcd_sequencer #(
  parameter int unsigned POWER_UP_CYCLES   = 750000,
  parameter int unsigned WAKE_LONG_CYCLES  = 250000,
  parameter int unsigned WAKE_SHORT_CYCLES = 8000,
  parameter int unsigned CMD_CYCLES        = 2000,
  parameter int unsigned CLEAR_CYCLES      = 82000,
  parameter int unsigned ENABLE_CYCLES     = 12
) (
  input  logic                      clk,
  input  logic                      rst,
  input  lcd_pkg::msg_sel_t         mode,
  input  lcd_pkg::lcd_step_t        step,
  input  logic                      expired,
  output lcd_pkg::step_idx_t        step_idx,
  output lcd_pkg::msg_sel_t         active_mode,
  output logic                      load,
  output logic [lcd_pkg::CNT_W-1:0] load_value,
  output lcd_pkg::lcd_bus_t         lcd
);
  import lcd_pkg::*;

  typedef enum logic [2:0] {
    st_power_up,
    st_setup,
    st_pulse,
    st_hold,
    st_done
  } state_t;

  localparam step_idx_t LAST_STEP = step_idx_t'(NUM_STEPS - 1);

  state_t           state;
  logic             run;
  logic             restart;
  logic [CNT_W-1:0] hold_cycles;

  function automatic logic [CNT_W-1:0] class_cycles(delay_class_t dly);
    case (dly)
      dly_wake_long:  return CNT_W'(WAKE_LONG_CYCLES);
      dly_wake_short: return CNT_W'(WAKE_SHORT_CYCLES);
      dly_clear:      return CNT_W'(CLEAR_CYCLES);
      default:        return CNT_W'(CMD_CYCLES);
    endcase
  endfunction

  // A fresh run after reset, or the selected message no longer matches
  assign restart     = !run || (mode != active_mode);
  assign hold_cycles = class_cycles(step.dly);

  // Timer is loaded on the edge that enters each timed phase
  always_comb begin
    load       = 1'b0;
    load_value = '0;
    if (restart) begin
      load       = 1'b1;
      load_value = CNT_W'(POWER_UP_CYCLES);
    end else if (state == st_setup) begin
      load       = 1'b1;
      load_value = CNT_W'(ENABLE_CYCLES);
    end else if (state == st_pulse && expired && step_idx != LAST_STEP) begin
      load       = 1'b1;
      load_value = hold_cycles;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state       <= st_power_up;
      run         <= 1'b0;
      active_mode <= msg_landing;
      step_idx    <= '0;
      lcd         <= '0;
    end else if (restart) begin
      state       <= st_power_up;
      run         <= 1'b1;
      active_mode <= mode;
      step_idx    <= '0;
      lcd         <= '0;
    end else begin
      case (state)
        st_power_up: begin
          if (expired) begin
            lcd.rs   <= step.rs;
            lcd.data <= step.data;
            state    <= st_setup;
          end
        end
        st_setup: begin
          lcd.e <= 1'b1;
          state <= st_pulse;
        end
        st_pulse: begin
          if (expired) begin
            lcd.e <= 1'b0;
            if (step_idx == LAST_STEP) begin
              state <= st_done;
            end else begin
              // Hold-off already loaded from this step, so move on now
              step_idx <= step_idx + step_idx_t'(1);
              state    <= st_hold;
            end
          end
        end
        st_hold: begin
          if (expired) begin
            lcd.rs   <= step.rs;
            lcd.data <= step.data;
            state    <= st_setup;
          end
        end
        st_done: begin
          lcd <= '0;
        end
        default: begin
          state <= st_power_up;
        end
      endcase
    end
  end

  a_no_enable_idle: assert property (@(posedge clk) disable iff (rst)
    state inside {st_power_up, st_done} |-> !lcd.e);

  a_data_stable: assert property (@(posedge clk) disable iff (rst)
    lcd.e |-> $stable(lcd.data) && $stable(lcd.rs));

endmodule

/* logic/lcd_top.sv */
`timescale 1ns/1ps

module lcd_top #(
  parameter int unsigned POWER_UP_CYCLES   = 750000,
  parameter int unsigned WAKE_LONG_CYCLES  = 250000,
  parameter int unsigned WAKE_SHORT_CYCLES = 8000,
  parameter int unsigned CMD_CYCLES        = 2000,
  parameter int unsigned CLEAR_CYCLES      = 82000,
  parameter int unsigned ENABLE_CYCLES     = 12
) (
  input  logic              clk,
  input  logic              rst,
  input  lcd_pkg::msg_sel_t mode,
  output lcd_pkg::lcd_bus_t lcd
);
  import lcd_pkg::*;

  step_idx_t        step_idx;
  msg_sel_t         active_mode;
  lcd_step_t        step;
  logic             load;
  logic [CNT_W-1:0] load_value;
  logic             expired;

  lcd_sequencer #(
    .POWER_UP_CYCLES   (POWER_UP_CYCLES),
    .WAKE_LONG_CYCLES  (WAKE_LONG_CYCLES),
    .WAKE_SHORT_CYCLES (WAKE_SHORT_CYCLES),
    .CMD_CYCLES        (CMD_CYCLES),
    .CLEAR_CYCLES      (CLEAR_CYCLES),
    .ENABLE_CYCLES     (ENABLE_CYCLES)
  ) u_seq (
    .clk         (clk),
    .rst         (rst),
    .mode        (mode),
    .step        (step),
    .expired     (expired),
    .step_idx    (step_idx),
    .active_mode (active_mode),
    .load        (load),
    .load_value  (load_value),
    .lcd         (lcd)
  );

  lcd_delay_timer u_timer (
    .clk        (clk),
    .rst        (rst),
    .load       (load),
    .load_value (load_value),
    .expired    (expired)
  );

  lcd_step_rom u_rom (
    .step_idx    (step_idx),
    .active_mode (active_mode),
    .step        (step)
  );

endmodule

/* dv/lcd_tb.sv */
`timescale 1ns/1ps

module lcd_tb;
  import lcd_pkg::*;

  localparam int POWER_UP   = 40;
  localparam int WAKE_LONG  = 30;
  localparam int WAKE_SHORT = 12;
  localparam int CMD        = 6;
  localparam int CLEAR      = 20;
  localparam int ENABLE     = 3;

  // One full run writes 8 commands and 14 characters
  localparam int NUM_WR     = 22;
  localparam int MAX_WR     = 128;
  localparam int WAIT_LIMIT = 2000;

  typedef struct packed {
    logic       rs;
    logic [7:0] data;
  } write_t;

  logic     clk;
  logic     rst;
  msg_sel_t mode;
  lcd_bus_t lcd;
  integer   seed;

  // Bus monitor record with one entry per enable pulse
  logic       wr_rs   [0:MAX_WR-1];
  logic [7:0] wr_data [0:MAX_WR-1];
  int         wr_gap  [0:MAX_WR-1];
  int         n_wr;
  logic       prev_e;
  int         low_cnt;
  int         hi_cnt;
  msg_sel_t   mode_q;

  lcd_top #(
    .POWER_UP_CYCLES   (POWER_UP),
    .WAKE_LONG_CYCLES  (WAKE_LONG),
    .WAKE_SHORT_CYCLES (WAKE_SHORT),
    .CMD_CYCLES        (CMD),
    .CLEAR_CYCLES      (CLEAR),
    .ENABLE_CYCLES     (ENABLE)
  ) dut0 (
    .clk  (clk),
    .rst  (rst),
    .mode (mode),
    .lcd  (lcd)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("TB FAILED");
    $fatal(1, "Stopped at first error");
  endtask

  // Byte and register select of the write at position idx of a run
  function automatic write_t expected_step(input msg_sel_t m, input int idx);
    logic [14*8-1:0] text;
    write_t          w;
    text = (m == msg_takeoff) ? "FLIGHT TAKEOFF" : "FLIGHT LANDING";
    w.rs = 1'b0;
    case (idx)
      0, 1, 2: w.data = 8'h30;
      3:       w.data = 8'h38;
      4:       w.data = 8'h06;
      5:       w.data = 8'h0C;
      6:       w.data = 8'h01;
      7:       w.data = 8'h80;
      default: begin
        w.rs   = 1'b1;
        w.data = text[8*(21 - idx) +: 8];
      end
    endcase
    return w;
  endfunction

  // Minimum low cycles after write idx is its hold-off plus one setup cycle
  function automatic int expected_gap(input int idx);
    case (idx)
      0:       return WAKE_LONG + 1;
      1, 2:    return WAKE_SHORT + 1;
      6:       return CLEAR + 1;
      default: return CMD + 1;
    endcase
  endfunction

  // Sampled on the rising edge before the DUT's outputs move
  always @(posedge clk) begin
    if (rst) begin
      prev_e  = 1'b0;
      low_cnt = 0;
      hi_cnt  = 0;
      n_wr    = 0;
    end else if (lcd.e) begin
      if (!prev_e) begin
        wr_gap[n_wr]  = low_cnt;
        wr_rs[n_wr]   = lcd.rs;
        wr_data[n_wr] = lcd.data;
        hi_cnt        = 0;
      end
      assert (lcd.data == wr_data[n_wr]) else
        abort_run($sformatf("** Error: lcd.data moved during write %0d: %h then %h",
                            n_wr, wr_data[n_wr], lcd.data));
      assert (lcd.rs == wr_rs[n_wr]) else
        abort_run($sformatf("** Error: lcd.rs moved during write %0d: %h then %h",
                            n_wr, wr_rs[n_wr], lcd.rs));
      hi_cnt++;
      prev_e = 1'b1;
    end else begin
      if (prev_e) begin
        assert (hi_cnt == ENABLE) else
          abort_run($sformatf("** Error: lcd.e width on write %0d expected %h got %h",
                              n_wr, ENABLE, hi_cnt));
        n_wr++;
        low_cnt = 0;
      end
      // Gap before a restarted run counts from the mode change
      if (mode != mode_q) begin
        low_cnt = 0;
      end
      low_cnt++;
      prev_e = 1'b0;
    end
    mode_q = mode;
  end

  task automatic wait_writes(input int target, input string what);
    int cycles;
    cycles = 0;
    while (n_wr < target) begin
      @(negedge clk);
      cycles++;
      if (cycles > WAIT_LIMIT) begin
        abort_run($sformatf("Timeout after %0d cycles waiting for the %s", cycles, what));
      end
    end
  endtask

  // Compare count recorded writes from index first with one run of mode m
  task automatic check_run(input int first, input msg_sel_t m, input int count);
    write_t exp;
    int     w;
    int     min_gap;
    for (int i = 0; i < count; i++) begin
      w       = first + i;
      exp     = expected_step(m, i);
      min_gap = (i == 0) ? POWER_UP : expected_gap(i - 1);
      assert (wr_rs[w] == exp.rs) else
        abort_run($sformatf("** Error: lcd.rs on write %0d expected %h got %h",
                            w, exp.rs, wr_rs[w]));
      assert (wr_data[w] == exp.data) else
        abort_run($sformatf("** Error: lcd.data on write %0d expected %h got %h",
                            w, exp.data, wr_data[w]));
      assert (wr_gap[w] >= min_gap) else
        abort_run($sformatf("** Error: lcd.e gap before write %0d expected >= %h got %h",
                            w, min_gap, wr_gap[w]));
    end
  endtask

  task automatic check_idle(input int cycles);
    for (int i = 0; i < cycles; i++) begin
      @(negedge clk);
      assert (lcd.e == 1'b0) else
        abort_run($sformatf("** Error: lcd.e after the last write expected %h got %h",
                            1'b0, lcd.e));
    end
  endtask

  initial begin
    int k;
    int extra;
    int base;
    seed = 32'h9ddc;
    rst  = 1'b1;
    mode = msg_landing;
    repeat (3) @(negedge clk);
    rst = 1'b0;

    wait_writes(NUM_WR, "landing run after reset");
    check_run(0, msg_landing, NUM_WR);
    check_idle(200);

    // Mode change while the bus is idle
    mode = msg_takeoff;
    wait_writes(2 * NUM_WR, "takeoff run");
    check_run(NUM_WR, msg_takeoff, NUM_WR);
    check_idle(200);

    // Landing run cut short during a hold-off
    k     = 1 + ({$random(seed)} % 20);
    extra = {$random(seed)} % 4;
    mode  = msg_landing;
    wait_writes(2 * NUM_WR + k, "interrupted landing run");
    repeat (extra) @(negedge clk);
    mode = msg_takeoff;
    base = 2 * NUM_WR + k;
    wait_writes(base + NUM_WR, "takeoff run after the interruption");
    check_run(2 * NUM_WR, msg_landing, k);
    check_run(base, msg_takeoff, NUM_WR);
    check_idle(200);

    $display("TB PASSED");
    $finish;
  end

endmodule

/* compile.f */
logic/lcd_pkg.sv
logic/lcd_delay_timer.sv
logic/lcd_step_rom.sv
logic/lcd_sequencer.sv
logic/lcd_top.sv
dv/lcd_tb.sv

/* Makefile */
SIM  := obj_dir/Vlcd_tb
SRCS := $(shell grep '\.sv$$' compile.f)

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): compile.f $(SRCS)
	verilator --binary --timing --assert -j 0 --top-module lcd_tb -f compile.f

# The simulator exits non-zero on $fatal, so make fails with it
run: $(SIM)
	./$(SIM)

clean:
	rm -rf obj_dir
